/* rtl/vldu_pkg.sv */
`default_nettype none

package vldu_pkg;

  ////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////

  // Lanes and bytes per lane word
  localparam int unsigned NrLanes   = 4;
  localparam int unsigned LaneBytes = 8;
  // One register-file word spans all lanes
  localparam int unsigned WordBytes = NrLanes * LaneBytes;
  // Read data bus width in bytes
  localparam int unsigned BeatBytes = 16;

  // Queue depths
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;

  // Instruction ids and vector length
  localparam int unsigned NrVInsn   = 8;
  localparam int unsigned VlWidth   = 10;
  // Words per vector register, spacing of the register base addresses
  localparam int unsigned VRegWords = 32;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [9:0]                 vaddr_t;
  // Byte counters, vl scaled by up to 8 bytes per element
  typedef logic [VlWidth+2:0]         bcnt_t;

  // Vector load as it comes from the sequencer
  typedef struct packed {
    vid_t               id;
    logic [VlWidth-1:0] vl;    // Element count, at least 1
    logic [2:0]         vsew;  // log2 of the element bytes, 0 to 3
    logic [4:0]         vd;
  } load_req_t;

  // Write request towards one lane
  typedef struct packed {
    vid_t                      id;
    vaddr_t                    addr;
    logic [LaneBytes*8-1:0]    wdata;
    logic [LaneBytes-1:0]      be;
  } lane_result_t;

  typedef struct packed {
    logic [BeatBytes*8-1:0] data;
  } r_beat_t;

  typedef struct packed {
    logic valid;
    vid_t id;
  } load_done_t;

endpackage

`default_nettype wire

/* rtl/vldu_insn_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module vldu_insn_queue (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // Sequencer side
  input  wire vldu_pkg::load_req_t  load_req_i,
  input  wire                  load_req_valid_i,
  output logic                 load_req_ready_o,
  // Towards the beat packer
  output vldu_pkg::load_req_t  issue_insn_o,
  output logic                 issue_valid_o,
  input  wire                  issue_done_i,
  // From the result queue
  input  wire                  word_retired_i,
  // Completion report
  output vldu_pkg::load_done_t done_o
);

  ////////////////////////////////////////
  // Queue state
  ////////////////////////////////////////

  // Payload storage
  vldu_pkg::load_req_t insn_q [vldu_pkg::InsnQueueDepth];

  // One pointer per phase: accept, issue, commit
  logic [$clog2(vldu_pkg::InsnQueueDepth)-1:0] accept_pnt_q, accept_pnt_d;
  logic [$clog2(vldu_pkg::InsnQueueDepth)-1:0] issue_pnt_q, issue_pnt_d;
  logic [$clog2(vldu_pkg::InsnQueueDepth)-1:0] commit_pnt_q, commit_pnt_d;
  // Instructions still waiting to be issued / committed
  logic [$clog2(vldu_pkg::InsnQueueDepth):0]   issue_cnt_q, issue_cnt_d;
  logic [$clog2(vldu_pkg::InsnQueueDepth):0]   commit_cnt_q, commit_cnt_d;

  // Bytes of the committing instruction not yet written to the lanes
  vldu_pkg::bcnt_t commit_bytes_q, commit_bytes_d;

  logic accept;
  logic retire_insn;

  // Room while fewer than four instructions are uncommitted
  assign load_req_ready_o = (commit_cnt_q != vldu_pkg::InsnQueueDepth);
  assign accept           = load_req_valid_i && load_req_ready_o;

  // Head of the issue phase
  assign issue_insn_o  = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  always_comb begin : p_queue
    accept_pnt_d   = accept_pnt_q;
    issue_pnt_d    = issue_pnt_q;
    commit_pnt_d   = commit_pnt_q;
    issue_cnt_d    = issue_cnt_q;
    commit_cnt_d   = commit_cnt_q;
    commit_bytes_d = commit_bytes_q;
    retire_insn    = 1'b0;

    // Packer finished placing all bytes of the issuing instruction
    if (issue_done_i) begin
      issue_pnt_d = issue_pnt_q + 1'b1;
      issue_cnt_d = issue_cnt_q - 1'b1;
    end

    // One full word left the result queue
    if (word_retired_i) begin
      if (commit_bytes_q > vldu_pkg::bcnt_t'(vldu_pkg::WordBytes)) begin
        commit_bytes_d = commit_bytes_q - vldu_pkg::bcnt_t'(vldu_pkg::WordBytes);
      end else begin
        // Last word, the instruction is done
        commit_bytes_d = '0;
        retire_insn    = 1'b1;
        commit_pnt_d   = commit_pnt_q + 1'b1;
        commit_cnt_d   = commit_cnt_q - 1'b1;
        // Load the byte count of the next one in line
        if (commit_cnt_d != '0) begin
          commit_bytes_d = {3'b000, insn_q[commit_pnt_d].vl} << insn_q[commit_pnt_d].vsew;
        end
      end
    end

    // New instruction from the sequencer
    if (accept) begin
      // Empty commit phase, so this one commits next
      if (commit_cnt_d == '0) begin
        commit_bytes_d = {3'b000, load_req_i.vl} << load_req_i.vsew;
      end
      accept_pnt_d = accept_pnt_q + 1'b1;
      issue_cnt_d  = issue_cnt_d + 1'b1;
      commit_cnt_d = commit_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      commit_bytes_q <= '0;
      done_o         <= '0;
    end else begin
      accept_pnt_q   <= accept_pnt_d;
      issue_pnt_q    <= issue_pnt_d;
      commit_pnt_q   <= commit_pnt_d;
      issue_cnt_q    <= issue_cnt_d;
      commit_cnt_q   <= commit_cnt_d;
      commit_bytes_q <= commit_bytes_d;
      // Report in commit order, one cycle after the last word retires
      done_o.valid   <= retire_insn;
      done_o.id      <= insn_q[commit_pnt_q].id;
    end
  end

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= load_req_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/vldu_beat_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module vldu_beat_packer (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  // Issuing instruction
  input  wire vldu_pkg::load_req_t    issue_insn_i,
  input  wire                         issue_valid_i,
  output logic                        issue_done_o,
  // Read data bus
  input  wire vldu_pkg::r_beat_t      r_beat_i,
  input  wire                         r_valid_i,
  output logic                        r_ready_o,
  // Towards the result queue
  output logic                        push_o,
  output vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] push_word_o,
  input  wire                         full_i
);

  // Pointers into the beat and into the word being built
  logic [$clog2(vldu_pkg::BeatBytes):0] r_pnt_q, r_pnt_d;
  logic [$clog2(vldu_pkg::WordBytes):0] w_pnt_q, w_pnt_d;
  // Word index within the instruction
  vldu_pkg::vaddr_t word_idx_q, word_idx_d;
  // Bytes of the instruction still to place
  vldu_pkg::bcnt_t  issue_bytes_q, issue_bytes_d;

  // Word under construction, byte granular
  logic [vldu_pkg::WordBytes-1:0][7:0] data_q, data_d;
  logic [vldu_pkg::WordBytes-1:0]      be_q, be_d;

  logic [vldu_pkg::BeatBytes-1:0][7:0] beat_bytes;
  vldu_pkg::bcnt_t  total_bytes;
  vldu_pkg::bcnt_t  remaining;
  vldu_pkg::bcnt_t  n_bytes;
  vldu_pkg::bcnt_t  bytes_left;
  vldu_pkg::vaddr_t word_addr;
  logic             word_close;
  logic             beat_end;
  logic             fire;

  assign beat_bytes  = r_beat_i.data;
  assign total_bytes = {3'b000, issue_insn_i.vl} << issue_insn_i.vsew;
  // Nothing placed yet means a fresh instruction
  assign remaining   = (w_pnt_q == '0 && word_idx_q == '0) ? total_bytes : issue_bytes_q;

  ////////////////////////////////////////
  // Step size
  ////////////////////////////////////////

  // Limited by room in the word, bytes left in the beat and in the instruction
  always_comb begin : p_step
    n_bytes = vldu_pkg::bcnt_t'(vldu_pkg::WordBytes) - vldu_pkg::bcnt_t'(w_pnt_q);
    if (vldu_pkg::bcnt_t'(vldu_pkg::BeatBytes) - vldu_pkg::bcnt_t'(r_pnt_q) < n_bytes) begin
      n_bytes = vldu_pkg::bcnt_t'(vldu_pkg::BeatBytes) - vldu_pkg::bcnt_t'(r_pnt_q);
    end
    if (remaining < n_bytes) begin
      n_bytes = remaining;
    end
  end

  assign bytes_left = remaining - n_bytes;
  assign word_close = (vldu_pkg::bcnt_t'(w_pnt_q) + n_bytes ==
                       vldu_pkg::bcnt_t'(vldu_pkg::WordBytes)) || (bytes_left == '0);
  // Last instruction byte drops the rest of the beat
  assign beat_end   = (vldu_pkg::bcnt_t'(r_pnt_q) + n_bytes ==
                       vldu_pkg::bcnt_t'(vldu_pkg::BeatBytes)) || (bytes_left == '0);

  assign fire         = issue_valid_i && r_valid_i && !full_i;
  assign r_ready_o    = issue_valid_i && !full_i && beat_end;
  assign push_o       = fire && word_close;
  assign issue_done_o = fire && (bytes_left == '0);

  // Base of vd plus the word index
  assign word_addr = vldu_pkg::vaddr_t'(vldu_pkg::vaddr_t'(issue_insn_i.vd) *
                     vldu_pkg::VRegWords) + word_idx_q;

  ////////////////////////////////////////
  // Byte copy
  ////////////////////////////////////////

  always_comb begin : p_pack
    data_d = data_q;
    be_d   = be_q;
    if (fire) begin
      for (int i = 0; i < vldu_pkg::BeatBytes; i++) begin
        if (i < n_bytes) begin
          data_d[w_pnt_q + i] = beat_bytes[r_pnt_q + i];
          be_d[w_pnt_q + i]   = 1'b1;
        end
      end
    end
  end

  // Word byte b lands in lane b/8
  always_comb begin : p_word
    for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
      push_word_o[l].id    = issue_insn_i.id;
      push_word_o[l].addr  = word_addr;
      push_word_o[l].wdata = data_d[l*vldu_pkg::LaneBytes +: vldu_pkg::LaneBytes];
      push_word_o[l].be    = be_d[l*vldu_pkg::LaneBytes +: vldu_pkg::LaneBytes];
    end
  end

  always_comb begin : p_state
    r_pnt_d       = r_pnt_q;
    w_pnt_d       = w_pnt_q;
    word_idx_d    = word_idx_q;
    issue_bytes_d = issue_bytes_q;
    if (fire) begin
      issue_bytes_d = bytes_left;
      w_pnt_d       = w_pnt_q + n_bytes[$clog2(vldu_pkg::WordBytes):0];
      r_pnt_d       = r_pnt_q + n_bytes[$clog2(vldu_pkg::BeatBytes):0];
      if (word_close) begin
        w_pnt_d    = '0;
        word_idx_d = word_idx_q + 1'b1;
      end
      if (beat_end) begin
        r_pnt_d = '0;
      end
      // Instruction complete, rearm for the next one
      if (bytes_left == '0) begin
        word_idx_d    = '0;
        issue_bytes_d = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_pnt_q       <= '0;
      w_pnt_q       <= '0;
      word_idx_q    <= '0;
      issue_bytes_q <= '0;
      data_q        <= '0;
      be_q          <= '0;
    end else begin
      r_pnt_q       <= r_pnt_d;
      w_pnt_q       <= w_pnt_d;
      word_idx_q    <= word_idx_d;
      issue_bytes_q <= issue_bytes_d;
      // Start from an empty word after each push, unfilled bytes stay zero
      if (push_o) begin
        data_q <= '0;
        be_q   <= '0;
      end else begin
        data_q <= data_d;
        be_q   <= be_d;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/vldu_result_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module vldu_result_queue (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  // From the beat packer
  input  wire                          push_i,
  input  wire vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] push_word_i,
  output logic                         full_o,
  // Lane write ports
  output logic [vldu_pkg::NrLanes-1:0] lane_req_o,
  output vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] lane_result_o,
  input  wire  [vldu_pkg::NrLanes-1:0] lane_gnt_i,
  // Towards the instruction queue
  output logic                         word_retired_o
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // One word per entry, one request bit per lane
  vldu_pkg::lane_result_t [vldu_pkg::ResultQueueDepth-1:0][vldu_pkg::NrLanes-1:0] entry_q;
  logic [vldu_pkg::ResultQueueDepth-1:0][vldu_pkg::NrLanes-1:0] valid_q, valid_d;

  logic [$clog2(vldu_pkg::ResultQueueDepth)-1:0] wr_pnt_q, wr_pnt_d;
  logic [$clog2(vldu_pkg::ResultQueueDepth)-1:0] rd_pnt_q, rd_pnt_d;
  // Occupied entries
  logic [$clog2(vldu_pkg::ResultQueueDepth):0]   cnt_q, cnt_d;

  assign full_o = (cnt_q == vldu_pkg::ResultQueueDepth);

  // Head entry drives all lanes, each lane at its own pace
  assign lane_req_o    = valid_q[rd_pnt_q];
  assign lane_result_o = entry_q[rd_pnt_q];

  // Head occupied but every lane has taken its part
  assign word_retired_o = (cnt_q != '0) && (valid_q[rd_pnt_q] == '0);

  always_comb begin : p_ctrl
    valid_d  = valid_q;
    wr_pnt_d = wr_pnt_q;
    rd_pnt_d = rd_pnt_q;
    cnt_d    = cnt_q;

    // Granted lanes drop their request
    for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
      if (lane_req_o[l] && lane_gnt_i[l]) begin
        valid_d[rd_pnt_q][l] = 1'b0;
      end
    end

    // Free the head entry
    if (word_retired_o) begin
      rd_pnt_d = rd_pnt_q + 1'b1;
      cnt_d    = cnt_d - 1'b1;
    end

    // New word, requests go out next cycle
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
      wr_pnt_d          = wr_pnt_q + 1'b1;
      cnt_d             = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_pnt_q <= wr_pnt_d;
      rd_pnt_q <= rd_pnt_d;
      cnt_q    <= cnt_d;
    end
  end

  // Word payload
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entry_q[wr_pnt_q] <= push_word_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/vldu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vldu_top (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  // Sequencer
  input  wire vldu_pkg::load_req_t     load_req_i,
  input  wire                          load_req_valid_i,
  output logic                         load_req_ready_o,
  // Memory read data
  input  wire vldu_pkg::r_beat_t       r_beat_i,
  input  wire                          r_valid_i,
  output logic                         r_ready_o,
  // Lanes
  output logic [vldu_pkg::NrLanes-1:0] lane_req_o,
  output vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] lane_result_o,
  input  wire  [vldu_pkg::NrLanes-1:0] lane_gnt_i,
  // Completion
  output vldu_pkg::load_done_t         done_o
);

  ////////////////////////////////////////
  // Chain: queue, packer, result queue
  ////////////////////////////////////////

  vldu_pkg::load_req_t issue_insn;
  logic                issue_valid;
  logic                issue_done;
  logic                push;
  vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] push_word;
  logic                full;
  logic                word_retired;

  vldu_insn_queue i_insn_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .load_req_i       (load_req_i),
    .load_req_valid_i (load_req_valid_i),
    .load_req_ready_o (load_req_ready_o),
    .issue_insn_o     (issue_insn),
    .issue_valid_o    (issue_valid),
    .issue_done_i     (issue_done),
    .word_retired_i   (word_retired),
    .done_o           (done_o)
  );

  // Packs read beats into lane words
  vldu_beat_packer i_beat_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .r_beat_i      (r_beat_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .push_o        (push),
    .push_word_o   (push_word),
    .full_i        (full)
  );

  // Holds words until every lane grants
  vldu_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_word_i    (push_word),
    .full_o         (full),
    .lane_req_o     (lane_req_o),
    .lane_result_o  (lane_result_o),
    .lane_gnt_i     (lane_gnt_i),
    .word_retired_o (word_retired)
  );

endmodule

`default_nettype wire

/* testbench/tb_vldu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vldu;

  typedef vldu_pkg::lane_result_t [vldu_pkg::NrLanes-1:0] word_t;

  logic                          clk_i;
  logic                          rst_ni;
  vldu_pkg::load_req_t           load_req_i;
  logic                          load_req_valid_i;
  logic                          load_req_ready_o;
  vldu_pkg::r_beat_t             r_beat_i;
  logic                          r_valid_i;
  logic                          r_ready_o;
  logic [vldu_pkg::NrLanes-1:0]  lane_req_o;
  word_t                         lane_result_o;
  logic [vldu_pkg::NrLanes-1:0]  lane_gnt_i;
  vldu_pkg::load_done_t          done_o;

  int seed = 58;
  // Stress mode adds random gaps to r_valid and the lane grants
  logic beats_enable;
  logic stress;
  logic full_watch;

  // Beats of all accepted loads in issue order
  vldu_pkg::r_beat_t beats[$];
  int                beat_idx = 0;
  // Expected words and the next one each lane should see
  word_t             exp_words[$];
  int                rd_idx [vldu_pkg::NrLanes];
  vldu_pkg::vid_t    exp_done[$];

  vldu_top uut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .load_req_i       (load_req_i),
    .load_req_valid_i (load_req_valid_i),
    .load_req_ready_o (load_req_ready_o),
    .r_beat_i         (r_beat_i),
    .r_valid_i        (r_valid_i),
    .r_ready_o        (r_ready_o),
    .lane_req_o       (lane_req_o),
    .lane_result_o    (lane_result_o),
    .lane_gnt_i       (lane_gnt_i),
    .done_o           (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  // Word byte b is stream byte b and lands in lane b/8
  // Bytes past the end of the load stay zero
  function automatic vldu_pkg::lane_result_t expected_lane(input vldu_pkg::load_req_t req,
                                                           input int first_beat,
                                                           input int word, input int lane);
    vldu_pkg::lane_result_t res;
    int nbytes;
    int b;
    nbytes    = int'(req.vl) << req.vsew;
    res.id    = req.id;
    res.addr  = vldu_pkg::vaddr_t'(int'(req.vd) * vldu_pkg::VRegWords + word);
    res.wdata = '0;
    res.be    = '0;
    for (int j = 0; j < vldu_pkg::LaneBytes; j++) begin
      b = word * vldu_pkg::WordBytes + lane * vldu_pkg::LaneBytes + j;
      if (b < nbytes) begin
        res.wdata[j*8 +: 8] =
          beats[first_beat + b / vldu_pkg::BeatBytes].data[(b % vldu_pkg::BeatBytes)*8 +: 8];
        res.be[j] = 1'b1;
      end
    end
    return res;
  endfunction

  function automatic vldu_pkg::load_req_t make_load(input int id, input int vl,
                                                    input int vsew, input int vd);
    vldu_pkg::load_req_t req;
    req.id   = vldu_pkg::vid_t'(id);
    req.vl   = vl[vldu_pkg::VlWidth-1:0];
    req.vsew = vsew[2:0];
    req.vd   = vd[4:0];
    return req;
  endfunction

  task automatic report_failure();
    $display("Test failures found");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_lane_result(input int lane, input vldu_pkg::lane_result_t got,
                                   input vldu_pkg::lane_result_t exp);
    if (got !== exp) begin
      $display("** Error: lane_result_o[%0d] got %h, expected %h", lane, got, exp);
      report_failure();
    end
  endtask

  task automatic check_done(input vldu_pkg::load_done_t got, input vldu_pkg::load_done_t exp);
    if (got !== exp) begin
      $display("** Error: done_o got %h, expected %h", got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h, expected %h", name, got, exp);
      report_failure();
    end
  endtask

  // Compare every granted lane result and every done report
  always @(posedge clk_i) begin : compare
    vldu_pkg::load_done_t exp_d;
    if (rst_ni) begin
      for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
        if (lane_req_o[l] && lane_gnt_i[l]) begin
          if (rd_idx[l] >= exp_words.size()) begin
            $display("Lane %0d delivered a result that no load produced", l);
            report_failure();
          end
          check_lane_result(l, lane_result_o[l], exp_words[rd_idx[l]][l]);
          rd_idx[l]++;
        end
      end
      if (done_o.valid) begin
        if (exp_done.size() == 0) begin
          $display("done_o reported a load that was not outstanding");
          report_failure();
        end
        exp_d.valid = 1'b1;
        exp_d.id    = exp_done.pop_front();
        check_done(done_o, exp_d);
      end
      // Full queue keeps ready low up to the first done
      if (full_watch) begin
        if (done_o.valid) begin
          full_watch <= 1'b0;
        end else begin
          check_flag("load_req_ready_o", load_req_ready_o, 1'b0);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // Memory beats and lane grants
  always @(posedge clk_i) begin : drive
    logic [31:0] rnd;
    if (r_valid_i && r_ready_o) begin
      beat_idx++;
    end
    rnd = $random(seed);
    if (beats_enable && beat_idx < beats.size()) begin
      r_beat_i  <= beats[beat_idx];
      r_valid_i <= stress ? (rnd[2:0] != 3'd0) : 1'b1;
    end else begin
      r_valid_i <= 1'b0;
    end
    lane_gnt_i <= stress ? rnd[7:4] : '1;
  end

  // Records the expected words and beats and then hands the load over
  task automatic send_load(input vldu_pkg::load_req_t req);
    int nbytes;
    int nbeats;
    int first;
    int t;
    vldu_pkg::r_beat_t beat;
    word_t w;
    nbytes = int'(req.vl) << req.vsew;
    nbeats = (nbytes + vldu_pkg::BeatBytes - 1) / vldu_pkg::BeatBytes;
    first  = beats.size();
    for (int k = 0; k < nbeats; k++) begin
      for (int q = 0; q < vldu_pkg::BeatBytes / 4; q++) begin
        beat.data[q*32 +: 32] = $random(seed);
      end
      beats.push_back(beat);
    end
    for (int wi = 0; wi < (nbytes + vldu_pkg::WordBytes - 1) / vldu_pkg::WordBytes; wi++) begin
      for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
        w[l] = expected_lane(req, first, wi, l);
      end
      exp_words.push_back(w);
    end
    exp_done.push_back(req.id);
    @(posedge clk_i);
    load_req_i       <= req;
    load_req_valid_i <= 1'b1;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
      if (t > 200) begin
        $display("Timeout: load %0d was never accepted", req.id);
        report_failure();
      end
    end while (!load_req_ready_o);
    load_req_valid_i <= 1'b0;
  endtask

  // Waits until every word and every done has been seen
  task automatic wait_idle(input int limit);
    int  t;
    logic idle;
    t    = 0;
    idle = 1'b0;
    while (!idle) begin
      @(posedge clk_i);
      t++;
      idle = (exp_done.size() == 0);
      for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
        if (rd_idx[l] != exp_words.size()) begin
          idle = 1'b0;
        end
      end
      if (!idle && t > limit) begin
        $display("Timeout: outstanding loads did not complete in %0d cycles", limit);
        report_failure();
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_ni           = 1'b0;
    load_req_i       = '0;
    load_req_valid_i = 1'b0;
    r_beat_i         = '0;
    r_valid_i        = 1'b0;
    lane_gnt_i       = '0;
    beats_enable     = 1'b0;
    stress           = 1'b0;
    full_watch       = 1'b0;
    for (int l = 0; l < vldu_pkg::NrLanes; l++) begin
      rd_idx[l] = 0;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle outputs after reset
    @(posedge clk_i);
    check_flag("load_req_ready_o", load_req_ready_o, 1'b1);
    check_flag("r_ready_o", r_ready_o, 1'b0);
    check_flag("lane_req_o", |lane_req_o, 1'b0);
    check_flag("done_o.valid", done_o.valid, 1'b0);

    // Whole words before a short last word and a fresh load
    beats_enable <= 1'b1;
    send_load(make_load(0, 16, 3, 2));
    wait_idle(500);
    send_load(make_load(1, 5, 2, 7));
    send_load(make_load(2, 8, 0, 3));
    wait_idle(500);

    // Random loads under valid and grant back-pressure
    stress <= 1'b1;
    for (int i = 3; i < 11; i++) begin
      send_load(make_load(i % vldu_pkg::NrVInsn, 1 + ($unsigned($random(seed)) % 40),
                          $unsigned($random(seed)) % 4, $unsigned($random(seed)) % 24));
    end
    wait_idle(5000);

    // Four loads with no read data fill the instruction queue
    stress       <= 1'b0;
    beats_enable <= 1'b0;
    for (int i = 11; i < 15; i++) begin
      send_load(make_load(i % vldu_pkg::NrVInsn, 12, 1, 9 + i));
    end
    repeat (5) begin
      @(posedge clk_i);
      check_flag("load_req_ready_o", load_req_ready_o, 1'b0);
    end
    full_watch   <= 1'b1;
    beats_enable <= 1'b1;
    wait_idle(2000);
    check_flag("load_req_ready_o", load_req_ready_o, 1'b1);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/vldu_pkg.sv
rtl/vldu_insn_queue.sv
rtl/vldu_beat_packer.sv
rtl/vldu_result_queue.sv
rtl/vldu_top.sv
testbench/tb_vldu.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_vldu -f all.f -o tb_vldu

# A $fatal in the testbench ends the run with a failing exit status
run: compile
	./obj_dir/tb_vldu

clean:
	rm -rf obj_dir
